// File: verilog/decode_pkg.sv
// widths and depths for the fetch-to-decode front end
// opcode match/mask patterns for the reduced LoongArch32 subset
// op class, operand selector and privileged op enums
// pre-decode result and instruction buffer entry structs

`default_nettype none

package decode_pkg;

  // ==========================================================================
  // widths and depths
  // ==========================================================================
  localparam int FETCH_WIDTH  = 2;
  localparam int DECODE_WIDTH = 2;
  localparam int IBUF_DEPTH   = 8;
  localparam int IBUF_PTR_W   = 3;
  localparam int IBUF_CNT_W   = 4;
  localparam int XLEN         = 32;
  localparam int AREG_W       = 5;

  // link register for bl
  localparam logic [AREG_W-1:0] REG_RA = 5'd1;

  // ==========================================================================
  // opcode patterns
  // ==========================================================================
  typedef struct packed {
    logic [XLEN-1:0] match;
    logic [XLEN-1:0] mask;
  } opc_pat_t;

  localparam opc_pat_t OPC_ADD_W   = '{match: 32'h0010_0000, mask: 32'hFFFF_8000};
  localparam opc_pat_t OPC_ADDI_W  = '{match: 32'h0280_0000, mask: 32'hFFC0_0000};
  localparam opc_pat_t OPC_LD_W    = '{match: 32'h2880_0000, mask: 32'hFFC0_0000};
  localparam opc_pat_t OPC_ST_W    = '{match: 32'h2980_0000, mask: 32'hFFC0_0000};
  localparam opc_pat_t OPC_BEQ     = '{match: 32'h5800_0000, mask: 32'hFC00_0000};
  localparam opc_pat_t OPC_BL      = '{match: 32'h5400_0000, mask: 32'hFC00_0000};
  localparam opc_pat_t OPC_JIRL    = '{match: 32'h4C00_0000, mask: 32'hFC00_0000};
  // covers csrrd and csrwr too, told apart later by rj
  localparam opc_pat_t OPC_CSRXCHG = '{match: 32'h0400_0000, mask: 32'hFF00_0000};
  localparam opc_pat_t OPC_ERTN    = '{match: 32'h0648_3800, mask: 32'hFFFF_FFFF};

  // ==========================================================================
  // enums
  // ==========================================================================
  typedef enum logic [2:0] {
    OP_ALU,
    OP_MEM,
    OP_BR,
    OP_PRIV,
    OP_ILLEGAL
  } op_class_e;

  typedef enum logic [1:0] {
    SRC_R0,
    SRC_RD,
    SRC_RJ,
    SRC_RK
  } src_type_e;

  typedef enum logic [1:0] {
    DEST_R0,
    DEST_RD,
    DEST_JD,
    DEST_RA
  } dest_type_e;

  typedef enum logic [2:0] {
    PRIV_NONE,
    PRIV_CSR_READ,
    PRIV_CSR_WRITE,
    PRIV_CSR_XCHG,
    PRIV_ERTN
  } priv_op_e;

  // ==========================================================================
  // structs
  // ==========================================================================
  typedef struct packed {
    op_class_e  op_class;
    priv_op_e   priv_op;
    src_type_e  src0_type;
    src_type_e  src1_type;
    dest_type_e dest_type;
  } pre_oc_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    pre_oc_t         pre_oc;
  } ibuf_entry_t;

endpackage

`default_nettype wire

// File: verilog/ibuf_rd_if.sv
// read port between the instruction buffer and the decode lanes
// buffer side drives valid and entries, decode side drives ready

`timescale 1ns/1ps
`default_nettype none

interface ibuf_rd_if
  import decode_pkg::*;
();

  // bit k high when k-th oldest entry is present
  logic        [DECODE_WIDTH-1:0] valid;
  ibuf_entry_t [DECODE_WIDTH-1:0] entry;
  // consume all valid lanes at once
  logic                           ready;

  modport buffer (
    output valid,
    output entry,
    input  ready
  );

  modport decoder (
    input  valid,
    input  entry,
    output ready
  );

endinterface

`default_nettype wire

// File: verilog/pre_decoder.sv
// pre-decoder for one fetched instruction word
// classifies the opcode and picks operand-type selectors

`timescale 1ns/1ps
`default_nettype none

module pre_decoder
  import decode_pkg::*;
(
  input  logic [XLEN-1:0] instr_i,
  output pre_oc_t         pre_oc_o
);

  logic hit_add_w;
  logic hit_addi_w;
  logic hit_ld_w;
  logic hit_st_w;
  logic hit_beq;
  logic hit_bl;
  logic hit_jirl;
  logic hit_csr;
  logic hit_ertn;

  function automatic logic opc_hit(logic [XLEN-1:0] instr, opc_pat_t pat);
    return (instr & pat.mask) == pat.match;
  endfunction

  // ==========================================================================
  // pattern match
  // ==========================================================================
  assign hit_add_w  = opc_hit(instr_i, OPC_ADD_W);
  assign hit_addi_w = opc_hit(instr_i, OPC_ADDI_W);
  assign hit_ld_w   = opc_hit(instr_i, OPC_LD_W);
  assign hit_st_w   = opc_hit(instr_i, OPC_ST_W);
  assign hit_beq    = opc_hit(instr_i, OPC_BEQ);
  assign hit_bl     = opc_hit(instr_i, OPC_BL);
  assign hit_jirl   = opc_hit(instr_i, OPC_JIRL);
  assign hit_csr    = opc_hit(instr_i, OPC_CSRXCHG);
  assign hit_ertn   = opc_hit(instr_i, OPC_ERTN);

  // ==========================================================================
  // classification
  // ==========================================================================
  // pattern order is class, priv op, src0, src1 and dest
  always_comb begin
    priority case (1'b1)
      hit_add_w: begin
        pre_oc_o = '{OP_ALU, PRIV_NONE, SRC_RJ, SRC_RK, DEST_RD};
      end
      hit_addi_w: begin
        pre_oc_o = '{OP_ALU, PRIV_NONE, SRC_RJ, SRC_R0, DEST_RD};
      end
      hit_ld_w: begin
        pre_oc_o = '{OP_MEM, PRIV_NONE, SRC_RJ, SRC_R0, DEST_RD};
      end
      // store data comes from rd
      hit_st_w: begin
        pre_oc_o = '{OP_MEM, PRIV_NONE, SRC_RJ, SRC_RD, DEST_R0};
      end
      hit_beq: begin
        pre_oc_o = '{OP_BR, PRIV_NONE, SRC_RJ, SRC_RD, DEST_R0};
      end
      hit_bl: begin
        pre_oc_o = '{OP_BR, PRIV_NONE, SRC_R0, SRC_R0, DEST_RA};
      end
      hit_jirl: begin
        pre_oc_o = '{OP_BR, PRIV_NONE, SRC_RJ, SRC_R0, DEST_RD};
      end
      // refined to read/write/xchg in the decode lane
      hit_csr: begin
        pre_oc_o = '{OP_PRIV, PRIV_CSR_XCHG, SRC_RD, SRC_RJ, DEST_RD};
      end
      hit_ertn: begin
        pre_oc_o = '{OP_PRIV, PRIV_ERTN, SRC_R0, SRC_R0, DEST_R0};
      end
      default: begin
        pre_oc_o = '{OP_ILLEGAL, PRIV_NONE, SRC_R0, SRC_R0, DEST_R0};
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/instr_buffer.sv
// circular FIFO instruction buffer with multi-lane ports
// in-order compacting write of up to two lanes per cycle
// two oldest entries exposed for read
// flush empties the buffer

`timescale 1ns/1ps
`default_nettype none

module instr_buffer
  import decode_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             flush_i,
  input  logic        [FETCH_WIDTH-1:0]    wr_valid_i,
  input  ibuf_entry_t [FETCH_WIDTH-1:0]    wr_entry_i,
  output logic                             wr_ready_o,
  ibuf_rd_if.buffer                        rd
);

  ibuf_entry_t           mem [IBUF_DEPTH];

  logic [IBUF_PTR_W-1:0] head_q;
  logic [IBUF_PTR_W-1:0] tail_q;
  logic [IBUF_CNT_W-1:0] count_q;

  logic [IBUF_PTR_W-1:0] wr_off [FETCH_WIDTH];
  logic [IBUF_CNT_W-1:0] wr_num;
  logic [IBUF_CNT_W-1:0] wr_acc;
  logic [IBUF_CNT_W-1:0] rd_num;
  logic                  wr_fire;

  // ==========================================================================
  // write side
  // ==========================================================================
  // room for a full group regardless of the offered valids
  assign wr_ready_o = count_q <= IBUF_CNT_W'(IBUF_DEPTH - FETCH_WIDTH);
  assign wr_fire    = wr_ready_o & ~flush_i;
  assign wr_acc     = wr_fire ? wr_num : '0;

  // each valid lane lands after the valid lanes below it
  always_comb begin
    wr_num = '0;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      wr_off[i] = wr_num[IBUF_PTR_W-1:0];
      wr_num    = wr_num + IBUF_CNT_W'(wr_valid_i[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int i = 0; i < FETCH_WIDTH; i++) begin
        if (wr_valid_i[i]) begin
          mem[tail_q + wr_off[i]] <= wr_entry_i[i];
        end
      end
    end
  end

  // ==========================================================================
  // read side
  // ==========================================================================
  always_comb begin
    rd_num = '0;
    for (int k = 0; k < DECODE_WIDTH; k++) begin
      rd.valid[k] = count_q > IBUF_CNT_W'(k);
      rd.entry[k] = mem[head_q + IBUF_PTR_W'(k)];
      // ready takes every valid lane at once
      if (rd.ready && rd.valid[k]) begin
        rd_num = rd_num + IBUF_CNT_W'(1);
      end
    end
  end

  // ==========================================================================
  // pointers and occupancy
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush_i) begin
      // flush wins over same-edge write and read
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      head_q  <= head_q + rd_num[IBUF_PTR_W-1:0];
      tail_q  <= tail_q + wr_acc[IBUF_PTR_W-1:0];
      count_q <= count_q + wr_acc - rd_num;
    end
  end

endmodule

`default_nettype wire

// File: verilog/decode_lane.sv
// one decode lane fed from a buffered entry
// selects architectural register numbers and refines csr ops

`timescale 1ns/1ps
`default_nettype none

module decode_lane
  import decode_pkg::*;
(
  input  ibuf_entry_t       entry_i,
  output logic [XLEN-1:0]   pc_o,
  output op_class_e         op_o,
  output priv_op_e          priv_o,
  output logic [AREG_W-1:0] src0_o,
  output logic [AREG_W-1:0] src1_o,
  output logic [AREG_W-1:0] dest_o
);

  logic [AREG_W-1:0] rd;
  logic [AREG_W-1:0] rj;
  logic [AREG_W-1:0] rk;

  function automatic logic [AREG_W-1:0] sel_src(
    src_type_e         sel,
    logic [AREG_W-1:0] f_rd,
    logic [AREG_W-1:0] f_rj,
    logic [AREG_W-1:0] f_rk
  );
    case (sel)
      SRC_RD:  return f_rd;
      SRC_RJ:  return f_rj;
      SRC_RK:  return f_rk;
      default: return '0;
    endcase
  endfunction

  // instruction fields
  assign rd = entry_i.instr[4:0];
  assign rj = entry_i.instr[9:5];
  assign rk = entry_i.instr[14:10];

  assign pc_o   = entry_i.pc;
  assign op_o   = entry_i.pre_oc.op_class;
  assign src0_o = sel_src(entry_i.pre_oc.src0_type, rd, rj, rk);
  assign src1_o = sel_src(entry_i.pre_oc.src1_type, rd, rj, rk);

  always_comb begin
    case (entry_i.pre_oc.dest_type)
      DEST_RD: dest_o = rd;
      // rj or-ed with rd
      DEST_JD: dest_o = rj | rd;
      DEST_RA: dest_o = REG_RA;
      default: dest_o = '0;
    endcase
  end

  // csrrd is rj=0, csrwr is rj=1, else a real exchange
  always_comb begin
    priv_o = entry_i.pre_oc.priv_op;
    if (entry_i.pre_oc.priv_op == PRIV_CSR_XCHG) begin
      if (rj == AREG_W'(0)) begin
        priv_o = PRIV_CSR_READ;
      end else if (rj == AREG_W'(1)) begin
        priv_o = PRIV_CSR_WRITE;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/decode_front.sv
// decode front end top level
// pre-decoders per fetch lane, instruction buffer, decode lanes

`timescale 1ns/1ps
`default_nettype none

module decode_front
  import decode_pkg::*;
(
  input  logic                                        clk,
  input  logic                                        rst_n,
  // fetch side
  input  logic [FETCH_WIDTH-1:0]                      fetch_valid_i,
  input  logic [FETCH_WIDTH-1:0][XLEN-1:0]            fetch_pc_i,
  input  logic [FETCH_WIDTH-1:0][XLEN-1:0]            fetch_instr_i,
  output logic                                        fetch_ready_o,
  input  logic                                        flush_i,
  // decode side
  output logic [DECODE_WIDTH-1:0]                     dec_valid_o,
  input  logic                                        dec_ready_i,
  output logic [DECODE_WIDTH-1:0][XLEN-1:0]           dec_pc_o,
  output logic [DECODE_WIDTH-1:0][$bits(op_class_e)-1:0] dec_op_o,
  output logic [DECODE_WIDTH-1:0][$bits(priv_op_e)-1:0]  dec_priv_o,
  output logic [DECODE_WIDTH-1:0][AREG_W-1:0]         dec_src0_o,
  output logic [DECODE_WIDTH-1:0][AREG_W-1:0]         dec_src1_o,
  output logic [DECODE_WIDTH-1:0][AREG_W-1:0]         dec_dest_o
);

  pre_oc_t     [FETCH_WIDTH-1:0] pre_oc;
  ibuf_entry_t [FETCH_WIDTH-1:0] wr_entry;

  ibuf_rd_if rd_if ();

  // ==========================================================================
  // pre-decode and entry packing
  // ==========================================================================
  for (genvar i = 0; i < FETCH_WIDTH; i++) begin : g_pre
    pre_decoder i_pre_decoder (
      .instr_i  (fetch_instr_i[i]),
      .pre_oc_o (pre_oc[i])
    );

    assign wr_entry[i] = '{pc: fetch_pc_i[i], instr: fetch_instr_i[i], pre_oc: pre_oc[i]};
  end

  // ==========================================================================
  // instruction buffer
  // ==========================================================================
  assign rd_if.ready = dec_ready_i;
  assign dec_valid_o = rd_if.valid;

  instr_buffer i_instr_buffer (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .wr_valid_i (fetch_valid_i),
    .wr_entry_i (wr_entry),
    .wr_ready_o (fetch_ready_o),
    .rd         (rd_if.buffer)
  );

  // ==========================================================================
  // decode lanes
  // ==========================================================================
  for (genvar k = 0; k < DECODE_WIDTH; k++) begin : g_dec
    decode_lane i_decode_lane (
      .entry_i (rd_if.entry[k]),
      .pc_o    (dec_pc_o[k]),
      .op_o    (dec_op_o[k]),
      .priv_o  (dec_priv_o[k]),
      .src0_o  (dec_src0_o[k]),
      .src1_o  (dec_src1_o[k]),
      .dest_o  (dec_dest_o[k])
    );
  end

endmodule

`default_nettype wire

// File: tb/tb_decode_front.sv
// testbench for the decode front end
// vector reader, per-line driver and output checker, watchdog

`timescale 1ns/1ps
`default_nettype none

module tb_decode_front;

  localparam string VEC_FILE     = "tb/decode_vectors.txt";
  localparam int    MAX_VEC      = 64;
  localparam int    NUM_COLS     = 19;
  localparam int    RESET_CYCLES = 3;
  localparam int    WDOG_PER_VEC = 40;

  // column positions after the op letter in a vector line
  localparam int C_FV   = 0;
  localparam int C_PC0  = 1;
  localparam int C_IN0  = 2;
  localparam int C_PC1  = 3;
  localparam int C_IN1  = 4;
  localparam int C_EV   = 5;
  localparam int C_ER   = 6;
  // per lane pc, op, priv, src0, src1 and dest
  localparam int C_LANE = 7;

  logic                  clk;
  logic                  rst_n;
  logic [1:0]            fetch_valid_i;
  logic [1:0][31:0]      fetch_pc_i;
  logic [1:0][31:0]      fetch_instr_i;
  logic                  fetch_ready_o;
  logic                  flush_i;
  logic [1:0]            dec_valid_o;
  logic                  dec_ready_i;
  logic [1:0][31:0]      dec_pc_o;
  logic [1:0][2:0]       dec_op_o;
  logic [1:0][2:0]       dec_priv_o;
  logic [1:0][4:0]       dec_src0_o;
  logic [1:0][4:0]       dec_src1_o;
  logic [1:0][4:0]       dec_dest_o;

  logic [7:0]            op_mem  [MAX_VEC];
  logic [31:0]           vec_mem [MAX_VEC][NUM_COLS];
  int                    n_vec;
  int                    errors;
  integer                seed;
  logic                  vectors_loaded;

  decode_front i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_valid_i (fetch_valid_i),
    .fetch_pc_i    (fetch_pc_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_ready_o (fetch_ready_o),
    .flush_i       (flush_i),
    .dec_valid_o   (dec_valid_o),
    .dec_ready_i   (dec_ready_i),
    .dec_pc_o      (dec_pc_o),
    .dec_op_o      (dec_op_o),
    .dec_priv_o    (dec_priv_o),
    .dec_src0_o    (dec_src0_o),
    .dec_src1_o    (dec_src1_o),
    .dec_dest_o    (dec_dest_o)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // ==========================================================================
  // helpers
  // ==========================================================================
  task automatic load_vectors();
    int          fd;
    int          cnt;
    string       line;
    logic [7:0]  op_c;
    logic [31:0] f [NUM_COLS];
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      $display("could not open the vector file %s", VEC_FILE);
      errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      cnt = $sscanf(line,
        "%c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
        op_c, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
      if (cnt != NUM_COLS + 1 || n_vec >= MAX_VEC) begin
        $display("vector line could not be used: %s", line);
        errors++;
      end else begin
        op_mem[n_vec] = op_c;
        for (int c = 0; c < NUM_COLS; c++) begin
          vec_mem[n_vec][c] = f[c];
        end
        n_vec++;
      end
    end
    $fclose(fd);
    if (n_vec == 0) begin
      $display("the vector file holds no usable lines");
      errors++;
    end
  endtask

  task automatic compare_value(input int idx, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h (vector %0d, time %0t)",
               name, got, exp, idx, $time);
      errors++;
    end
  endtask

  task automatic check_outputs(input int idx);
    logic [31:0] exp_valid;
    int          base;
    exp_valid = vec_mem[idx][C_EV];
    compare_value(idx, "dec_valid_o", dec_valid_o, exp_valid);
    compare_value(idx, "fetch_ready_o", fetch_ready_o, vec_mem[idx][C_ER]);
    // lanes without a valid entry show stale storage
    for (int k = 0; k < 2; k++) begin
      if (exp_valid[k]) begin
        base = C_LANE + 6 * k;
        compare_value(idx, $sformatf("dec_pc_o[%0d]", k), dec_pc_o[k], vec_mem[idx][base]);
        compare_value(idx, $sformatf("dec_op_o[%0d]", k), dec_op_o[k], vec_mem[idx][base + 1]);
        compare_value(idx, $sformatf("dec_priv_o[%0d]", k), dec_priv_o[k],
                      vec_mem[idx][base + 2]);
        compare_value(idx, $sformatf("dec_src0_o[%0d]", k), dec_src0_o[k],
                      vec_mem[idx][base + 3]);
        compare_value(idx, $sformatf("dec_src1_o[%0d]", k), dec_src1_o[k],
                      vec_mem[idx][base + 4]);
        compare_value(idx, $sformatf("dec_dest_o[%0d]", k), dec_dest_o[k],
                      vec_mem[idx][base + 5]);
      end
    end
  endtask

  // drive one vector line and check before its acting edge
  task automatic run_vector(input int idx);
    int         idle;
    logic [7:0] op;
    op   = op_mem[idx];
    idle = $unsigned($random(seed)) % 3;
    repeat (idle) @(posedge clk);
    @(posedge clk);
    fetch_valid_i    <= 2'b00;
    dec_ready_i      <= 1'b0;
    flush_i          <= 1'b0;
    fetch_pc_i[0]    <= vec_mem[idx][C_PC0];
    fetch_instr_i[0] <= vec_mem[idx][C_IN0];
    fetch_pc_i[1]    <= vec_mem[idx][C_PC1];
    fetch_instr_i[1] <= vec_mem[idx][C_IN1];
    case (op)
      "W": fetch_valid_i <= vec_mem[idx][C_FV][1:0];
      "R": dec_ready_i <= 1'b1;
      // flush with a write offered on the same edge
      "F": begin
        flush_i       <= 1'b1;
        fetch_valid_i <= vec_mem[idx][C_FV][1:0];
      end
      "H": dec_ready_i <= 1'b0;
      default: begin
        $display("vector %0d has an unknown operation letter %c", idx, op);
        errors++;
      end
    endcase
    @(negedge clk);
    check_outputs(idx);
    @(posedge clk);
    fetch_valid_i <= 2'b00;
    dec_ready_i   <= 1'b0;
    flush_i       <= 1'b0;
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================
  initial begin
    rst_n          = 1'b0;
    fetch_valid_i  = 2'b00;
    fetch_pc_i     = '0;
    fetch_instr_i  = '0;
    flush_i        = 1'b0;
    dec_ready_i    = 1'b0;
    n_vec          = 0;
    errors         = 0;
    seed           = 92;
    vectors_loaded = 1'b0;
    load_vectors();
    vectors_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < n_vec; i++) begin
      run_vector(i);
    end
    $display("%0d vector lines run, %0d errors", n_vec, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (vectors_loaded);
    repeat (RESET_CYCLES + WDOG_PER_VEC * n_vec) @(posedge clk);
    $display("the run took too long and was stopped by the watchdog");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: decode_front.f
verilog/decode_pkg.sv
verilog/ibuf_rd_if.sv
verilog/pre_decoder.sv
verilog/instr_buffer.sv
verilog/decode_lane.sv
verilog/decode_front.sv
tb/tb_decode_front.sv

// File: tb/decode_vectors.txt
# op fv pc0 instr0 pc1 instr1 exp_valid exp_ready, then per lane: pc op priv src0 src1 dest
# op is W write, R read, F flush, H hold; outputs are checked before the line acts; hex columns
W 3 1000 00101483 1004 028040e6 0 1 0000 0 0 00 00 00 0000 0 0 00 00 00
R 0 0000 00000000 0000 00000000 3 1 1000 0 0 04 05 03 1004 0 0 07 00 06
W 1 1008 28800128 0000 ffffffff 0 1 0000 0 0 00 00 00 0000 0 0 00 00 00
W 2 0000 ffffffff 100c 2980016a 1 1 1008 1 0 09 00 08 0000 0 0 00 00 00
R 0 0000 00000000 0000 00000000 3 1 1008 1 0 09 00 08 100c 1 0 0b 0a 00
W 3 1010 580001ac 1014 54000010 0 1 0000 0 0 00 00 00 0000 0 0 00 00 00
W 3 1018 4c0001c1 101c 040004e3 3 1 1010 2 0 0d 0c 00 1014 2 0 00 00 01
R 0 0000 00000000 0000 00000000 3 1 1010 2 0 0d 0c 00 1014 2 0 00 00 01
R 0 0000 00000000 0000 00000000 3 1 1018 2 0 0e 00 01 101c 3 3 03 07 03
W 3 1020 04000404 1024 04000425 0 1 0000 0 0 00 00 00 0000 0 0 00 00 00
W 3 1028 06483800 102c ffffffff 3 1 1020 3 1 04 00 04 1024 3 2 05 01 05
R 0 0000 00000000 0000 00000000 3 1 1020 3 1 04 00 04 1024 3 2 05 01 05
R 0 0000 00000000 0000 00000000 3 1 1028 3 4 00 00 00 102c 4 0 00 00 00
W 3 1100 00101483 1104 028040e6 0 1 0000 0 0 00 00 00 0000 0 0 00 00 00
W 3 1108 28800128 110c 2980016a 3 1 1100 0 0 04 05 03 1104 0 0 07 00 06
W 3 1110 580001ac 1114 54000010 3 1 1100 0 0 04 05 03 1104 0 0 07 00 06
W 1 1118 4c0001c1 0000 00000000 3 1 1100 0 0 04 05 03 1104 0 0 07 00 06
H 0 0000 00000000 0000 00000000 3 0 1100 0 0 04 05 03 1104 0 0 07 00 06
H 0 0000 00000000 0000 00000000 3 0 1100 0 0 04 05 03 1104 0 0 07 00 06
R 0 0000 00000000 0000 00000000 3 0 1100 0 0 04 05 03 1104 0 0 07 00 06
R 0 0000 00000000 0000 00000000 3 1 1108 1 0 09 00 08 110c 1 0 0b 0a 00
R 0 0000 00000000 0000 00000000 3 1 1110 2 0 0d 0c 00 1114 2 0 00 00 01
R 0 0000 00000000 0000 00000000 1 1 1118 2 0 0e 00 01 0000 0 0 00 00 00
H 0 0000 00000000 0000 00000000 0 1 0000 0 0 00 00 00 0000 0 0 00 00 00
W 3 1200 040004e3 1204 06483800 0 1 0000 0 0 00 00 00 0000 0 0 00 00 00
W 3 1208 00101483 120c 28800128 3 1 1200 3 3 03 07 03 1204 3 4 00 00 00
F 3 1210 028040e6 1214 580001ac 3 1 1200 3 3 03 07 03 1204 3 4 00 00 00
H 0 0000 00000000 0000 00000000 0 1 0000 0 0 00 00 00 0000 0 0 00 00 00
W 3 1300 54000010 1304 06483800 0 1 0000 0 0 00 00 00 0000 0 0 00 00 00
R 0 0000 00000000 0000 00000000 3 1 1300 2 0 00 00 01 1304 3 4 00 00 00
H 0 0000 00000000 0000 00000000 0 1 0000 0 0 00 00 00 0000 0 0 00 00 00
